// ==== src/tpu_pkg.sv ====
package tpu_pkg;

    // grid geometry
    localparam int ARRAY_DIM = 4;

    // operand element and accumulator widths
    localparam int DATA_W = 8;
    localparam int ACC_W  = 32;

    // one A or B word carries a full row of lanes
    localparam int OPND_WORD_W = ARRAY_DIM * DATA_W;

    // one C word is a full accumulator column
    localparam int C_WORD_W = ARRAY_DIM * ACC_W;

    // buffer addressing
    localparam int INDEX_W = 16;

    // job dimensions K, M and N
    localparam int DIM_W = 8;

    // cycles from the last feed until PE(3,3) holds its final sum
    localparam int FLUSH_CYCLES = 7;

    // job sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FEED,
        SEQ_FLUSH,
        SEQ_WRITE
    } seq_state_t;

endpackage

// ==== src/tile_sequencer.sv ====
`timescale 1ns/1ps

module tile_sequencer
    import tpu_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_valid,
    input  logic [DIM_W-1:0]   k_dim,
    input  logic [DIM_W-1:0]   m_dim,
    input  logic [DIM_W-1:0]   n_dim,
    output logic               start_ready,
    output logic [INDEX_W-1:0] a_index,
    output logic [INDEX_W-1:0] b_index,
    output logic               feed,
    output logic               acc_clear,
    output logic [1:0]         col_sel,
    output logic               col_write
);

    seq_state_t         state;
    logic [DIM_W-1:0]   k_lat;
    logic [DIM_W-1:0]   m_lat;
    // last tile index ceil(dim/4) - 1
    logic [DIM_W-3:0]   m_last;
    logic [DIM_W-3:0]   n_last;
    logic [DIM_W-3:0]   mt_cnt;
    logic [DIM_W-3:0]   nt_cnt;
    logic [DIM_W-1:0]   k_cnt;
    logic [DIM_W-1:0]   flush_cnt;
    logic [1:0]         col_cnt;
    logic [INDEX_W-1:0] b_base;
    logic [DIM_W-1:0]   m_dim_m1;
    logic [DIM_W-1:0]   n_dim_m1;
    logic               accept;
    logic               last_k;
    logic               last_flush;
    logic               last_mt;
    logic               last_nt;

    assign accept     = start_valid && start_ready;
    assign m_dim_m1   = m_dim - 1'b1;
    assign n_dim_m1   = n_dim - 1'b1;
    assign last_k     = k_cnt == k_lat - 1'b1;
    assign last_flush = flush_cnt == DIM_W'(FLUSH_CYCLES - 1);
    assign last_mt    = mt_cnt == m_last;
    assign last_nt    = nt_cnt == n_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            k_lat     <= '0;
            m_lat     <= '0;
            m_last    <= '0;
            n_last    <= '0;
            mt_cnt    <= '0;
            nt_cnt    <= '0;
            k_cnt     <= '0;
            flush_cnt <= '0;
            col_cnt   <= '0;
            a_index   <= '0;
            b_index   <= '0;
            b_base    <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        k_lat   <= k_dim;
                        m_lat   <= m_dim;
                        m_last  <= m_dim_m1[DIM_W-1:2];
                        n_last  <= n_dim_m1[DIM_W-1:2];
                        mt_cnt  <= '0;
                        nt_cnt  <= '0;
                        k_cnt   <= '0;
                        b_base  <= '0;
                        state   <= SEQ_FEED;
                    end
                end
                SEQ_FEED: begin
                    // leaves a_index at (mt+1)*K and b_index at (nt+1)*K
                    a_index <= a_index + 1'b1;
                    b_index <= b_index + 1'b1;
                    if (last_k) begin
                        k_cnt <= '0;
                        state <= SEQ_FLUSH;
                    end else begin
                        k_cnt <= k_cnt + 1'b1;
                    end
                end
                SEQ_FLUSH: begin
                    if (last_flush) begin
                        flush_cnt <= '0;
                        state     <= SEQ_WRITE;
                    end else begin
                        flush_cnt <= flush_cnt + 1'b1;
                    end
                end
                SEQ_WRITE: begin
                    col_cnt <= col_cnt + 1'b1;
                    if (col_cnt == 2'd3) begin
                        if (!last_mt) begin
                            // next m tile reuses the same B rows
                            mt_cnt  <= mt_cnt + 1'b1;
                            b_index <= b_base;
                            state   <= SEQ_FEED;
                        end else if (!last_nt) begin
                            mt_cnt  <= '0;
                            nt_cnt  <= nt_cnt + 1'b1;
                            a_index <= '0;
                            b_base  <= b_index;
                            state   <= SEQ_FEED;
                        end else begin
                            a_index <= '0;
                            b_index <= '0;
                            state   <= SEQ_IDLE;
                        end
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    assign start_ready = state == SEQ_IDLE;
    assign feed        = state == SEQ_FEED;
    assign acc_clear   = feed && k_cnt == '0;
    assign col_sel     = col_cnt;
    // padded columns past M are dropped
    assign col_write   = state == SEQ_WRITE && {mt_cnt, col_cnt} < m_lat;

    // feed cycles of a tile are contiguous and open with the clear
    feed_contiguous: assert property (
        @(posedge clk) disable iff (!rst_n)
        feed |-> acc_clear || $past(feed)
    );

    // first column follows the flush and the rest follow back to back
    write_after_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        col_write |-> $past(state) == (col_sel == 2'd0 ? SEQ_FLUSH : SEQ_WRITE)
    );

endmodule

// ==== src/operand_skew.sv ====
`timescale 1ns/1ps

module operand_skew
    import tpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   feed,
    input  logic [OPND_WORD_W-1:0] a_data,
    input  logic [OPND_WORD_W-1:0] b_data,
    output logic [OPND_WORD_W-1:0] top_lanes,
    output logic [OPND_WORD_W-1:0] left_lanes
);

    // lane l is delayed by l+1 cycles, lane 0 in the top byte
    for (genvar l = 0; l < ARRAY_DIM; l++) begin : g_lane
        logic [DATA_W-1:0] a_dly [l+1];
        logic [DATA_W-1:0] b_dly [l+1];
        logic [DATA_W-1:0] a_lane;
        logic [DATA_W-1:0] b_lane;

        // zeros enter while not feeding
        assign a_lane = feed ? a_data[OPND_WORD_W-1-l*DATA_W -: DATA_W] : '0;
        assign b_lane = feed ? b_data[OPND_WORD_W-1-l*DATA_W -: DATA_W] : '0;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int i = 0; i <= l; i++) begin
                    a_dly[i] <= '0;
                    b_dly[i] <= '0;
                end
            end else begin
                a_dly[0] <= a_lane;
                b_dly[0] <= b_lane;
                for (int i = 1; i <= l; i++) begin
                    a_dly[i] <= a_dly[i-1];
                    b_dly[i] <= b_dly[i-1];
                end
            end
        end

        // A lane c feeds array column c, B lane r feeds array row r
        assign top_lanes[OPND_WORD_W-1-l*DATA_W -: DATA_W]  = a_dly[l];
        assign left_lanes[OPND_WORD_W-1-l*DATA_W -: DATA_W] = b_dly[l];
    end

endmodule

// ==== src/mac_pe.sv ====
`timescale 1ns/1ps

module mac_pe
    import tpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,
    input  logic [DATA_W-1:0] a_in,
    input  logic [DATA_W-1:0] b_in,
    output logic [DATA_W-1:0] a_out,
    output logic [DATA_W-1:0] b_out,
    output logic [ACC_W-1:0]  acc
);

    logic [2*DATA_W-1:0] product;
    logic [ACC_W-1:0]    acc_base;

    assign product  = a_in * b_in;
    // clear restarts the sum with this cycle's product
    assign acc_base = clear ? '0 : acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else begin
            // a moves down, b moves right
            a_out <= a_in;
            b_out <= b_in;
            acc   <= acc_base + {{(ACC_W-2*DATA_W){1'b0}}, product};
        end
    end

endmodule

// ==== src/result_drain.sv ====
`timescale 1ns/1ps

module result_drain
    import tpu_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start_accept,
    input  logic [ARRAY_DIM*ARRAY_DIM*ACC_W-1:0] acc_flat,
    input  logic [1:0]                           col_sel,
    input  logic                                 col_write,
    output logic                                 c_wr_en,
    output logic [INDEX_W-1:0]                   c_index,
    output logic [C_WORD_W-1:0]                  c_data
);

    logic [C_WORD_W-1:0] col_word;

    // row r of the selected column goes to lane r, lane 0 on top
    always_comb begin
        for (int r = 0; r < ARRAY_DIM; r++) begin
            col_word[C_WORD_W-1-r*ACC_W -: ACC_W] =
                acc_flat[(r*ARRAY_DIM + int'(col_sel))*ACC_W +: ACC_W];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_wr_en <= 1'b0;
        end else begin
            c_wr_en <= col_write;
        end
    end

    always_ff @(posedge clk) begin
        if (col_write) begin
            c_data <= col_word;
        end
    end

    // index of the write currently on the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_index <= '0;
        end else if (start_accept) begin
            c_index <= '0;
        end else if (c_wr_en) begin
            c_index <= c_index + 1'b1;
        end
    end

    c_index_no_wrap: assert property (
        @(posedge clk) disable iff (!rst_n)
        c_wr_en && !start_accept |=> c_index != '0
    );

endmodule

// ==== src/systolic_tpu.sv ====
`timescale 1ns/1ps

module systolic_tpu
    import tpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_valid,
    output logic                   start_ready,
    input  logic [DIM_W-1:0]       k_dim,
    input  logic [DIM_W-1:0]       m_dim,
    input  logic [DIM_W-1:0]       n_dim,
    output logic [INDEX_W-1:0]     a_index,
    input  logic [OPND_WORD_W-1:0] a_data,
    output logic [INDEX_W-1:0]     b_index,
    input  logic [OPND_WORD_W-1:0] b_data,
    output logic                   c_wr_en,
    output logic [INDEX_W-1:0]     c_index,
    output logic [C_WORD_W-1:0]    c_data
);

    logic                                 feed;
    logic                                 acc_clear;
    logic [1:0]                           col_sel;
    logic                                 col_write;
    logic                                 start_accept;
    logic [OPND_WORD_W-1:0]               top_lanes;
    logic [OPND_WORD_W-1:0]               left_lanes;
    logic [ARRAY_DIM*ARRAY_DIM*ACC_W-1:0] acc_flat;
    // a_link[r][c] enters PE(r,c) from above, b_link[r][c] from the left
    logic [DATA_W-1:0]                    a_link [ARRAY_DIM+1][ARRAY_DIM];
    logic [DATA_W-1:0]                    b_link [ARRAY_DIM][ARRAY_DIM+1];

    assign start_accept = start_valid && start_ready;

    tile_sequencer tile_sequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_valid (start_valid),
        .k_dim       (k_dim),
        .m_dim       (m_dim),
        .n_dim       (n_dim),
        .start_ready (start_ready),
        .a_index     (a_index),
        .b_index     (b_index),
        .feed        (feed),
        .acc_clear   (acc_clear),
        .col_sel     (col_sel),
        .col_write   (col_write)
    );

    operand_skew operand_skew_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .feed       (feed),
        .a_data     (a_data),
        .b_data     (b_data),
        .top_lanes  (top_lanes),
        .left_lanes (left_lanes)
    );

    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_edge
        assign a_link[0][i] = top_lanes[OPND_WORD_W-1-i*DATA_W -: DATA_W];
        assign b_link[i][0] = left_lanes[OPND_WORD_W-1-i*DATA_W -: DATA_W];
    end

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
            mac_pe mac_pe_i (
                .clk   (clk),
                .rst_n (rst_n),
                .clear (acc_clear),
                .a_in  (a_link[r][c]),
                .b_in  (b_link[r][c]),
                .a_out (a_link[r+1][c]),
                .b_out (b_link[r][c+1]),
                .acc   (acc_flat[(r*ARRAY_DIM+c)*ACC_W +: ACC_W])
            );
        end
    end

    result_drain result_drain_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_accept (start_accept),
        .acc_flat     (acc_flat),
        .col_sel      (col_sel),
        .col_write    (col_write),
        .c_wr_en      (c_wr_en),
        .c_index      (c_index),
        .c_data       (c_data)
    );

endmodule

// ==== tests/tb_systolic_tpu.sv ====
`timescale 1ns/1ps

module tb_systolic_tpu
    import tpu_pkg::*;
();

    logic                   clk;
    logic                   rst_n;
    logic                   start_valid;
    logic                   start_ready;
    logic [DIM_W-1:0]       k_dim;
    logic [DIM_W-1:0]       m_dim;
    logic [DIM_W-1:0]       n_dim;
    logic [INDEX_W-1:0]     a_index;
    logic [OPND_WORD_W-1:0] a_data;
    logic [INDEX_W-1:0]     b_index;
    logic [OPND_WORD_W-1:0] b_data;
    logic                   c_wr_en;
    logic [INDEX_W-1:0]     c_index;
    logic [C_WORD_W-1:0]    c_data;

    // A and B buffer models
    logic [OPND_WORD_W-1:0] a_mem [256];
    logic [OPND_WORD_W-1:0] b_mem [256];

    // C writes still owed by the engine in order
    logic [INDEX_W-1:0]     exp_index_q [$];
    logic [C_WORD_W-1:0]    exp_data_q [$];

    int error_count;
    int check_count;
    int writes_seen;
    bit aborted;

    systolic_tpu systolic_tpu_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .k_dim       (k_dim),
        .m_dim       (m_dim),
        .n_dim       (n_dim),
        .a_index     (a_index),
        .a_data      (a_data),
        .b_index     (b_index),
        .b_data      (b_data),
        .c_wr_en     (c_wr_en),
        .c_index     (c_index),
        .c_data      (c_data)
    );

    // buffers answer in the same cycle as the index
    assign a_data = a_mem[a_index[7:0]];
    assign b_data = b_mem[b_index[7:0]];

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [C_WORD_W-1:0] got,
                               input logic [C_WORD_W-1:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERROR: %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
        end
    endtask

    // lane 0 sits in the top byte of a word
    function automatic logic [DATA_W-1:0] lane_of(input logic [OPND_WORD_W-1:0] word,
                                                  input int l);
        return DATA_W'(word >> ((ARRAY_DIM - 1 - l) * DATA_W));
    endfunction

    task automatic fill_buffers();
        for (int i = 0; i < 256; i++) begin
            a_mem[i] = $urandom;
            b_mem[i] = $urandom;
        end
    endtask

    task automatic build_expected(input int k, input int m, input int n);
        logic [C_WORD_W-1:0] word;
        logic [ACC_W-1:0]    sum;
        logic [DATA_W-1:0]   a_elem;
        logic [DATA_W-1:0]   b_elem;
        for (int nt = 0; nt < (n + 3) / 4; nt++) begin
            for (int mt = 0; mt < (m + 3) / 4; mt++) begin
                for (int c = 0; c < ARRAY_DIM; c++) begin
                    // padded columns are never written
                    if (ARRAY_DIM * mt + c < m) begin
                        word = '0;
                        for (int r = 0; r < ARRAY_DIM; r++) begin
                            sum = '0;
                            for (int kk = 0; kk < k; kk++) begin
                                a_elem = lane_of(a_mem[mt * k + kk], c);
                                b_elem = lane_of(b_mem[nt * k + kk], r);
                                sum = sum + ACC_W'(a_elem) * ACC_W'(b_elem);
                            end
                            word = (word << ACC_W) | C_WORD_W'(sum);
                        end
                        exp_index_q.push_back(INDEX_W'(nt * m + ARRAY_DIM * mt + c));
                        exp_data_q.push_back(word);
                    end
                end
            end
        end
    endtask

    task automatic sample_write();
        if (c_wr_en) begin
            writes_seen++;
            if (exp_index_q.size() == 0) begin
                error_count++;
                $display("unexpected C write at index %0d with no result pending", c_index);
            end else begin
                check_value("c_index", C_WORD_W'(c_index), C_WORD_W'(exp_index_q.pop_front()));
                check_value("c_data", c_data, exp_data_q.pop_front());
            end
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
            sample_write();
        end
    endtask

    task automatic run_job(input int k, input int m, input int n, input bit hold_valid);
        int waited;
        int busy;
        int expected_busy;
        expected_busy = ((m + 3) / 4) * ((n + 3) / 4) * (k + 11);
        waited = 0;
        while (!start_ready && waited < 600) begin
            @(posedge clk);
            #1;
            sample_write();
            waited++;
        end
        if (!start_ready) begin
            $display("timeout: engine never became ready for a job with K=%0d M=%0d N=%0d",
                     k, m, n);
            error_count++;
            aborted = 1'b1;
            return;
        end
        fill_buffers();
        build_expected(k, m, n);
        writes_seen = 0;
        k_dim = DIM_W'(k);
        m_dim = DIM_W'(m);
        n_dim = DIM_W'(n);
        start_valid = 1'b1;
        // acceptance edge
        @(posedge clk);
        #1;
        if (!hold_valid) begin
            start_valid = 1'b0;
            // dimensions must already be latched
            k_dim = DIM_W'($urandom);
            m_dim = DIM_W'($urandom);
            n_dim = DIM_W'($urandom);
        end
        busy = 0;
        sample_write();
        while (!start_ready && busy < 5000) begin
            busy++;
            @(posedge clk);
            #1;
            sample_write();
        end
        start_valid = 1'b0;
        if (!start_ready) begin
            $display("timeout: job with K=%0d M=%0d N=%0d never finished", k, m, n);
            error_count++;
            aborted = 1'b1;
            return;
        end
        check_value("start_ready low cycles", C_WORD_W'(busy), C_WORD_W'(expected_busy));
        check_value("C write count", C_WORD_W'(writes_seen), C_WORD_W'(((n + 3) / 4) * m));
        exp_index_q.delete();
        exp_data_q.delete();
    endtask

    initial begin
        int k;
        int m;
        int n;
        int gap;
        bit hold;
        void'($urandom(32'h8be5e2ad));
        error_count = 0;
        check_count = 0;
        writes_seen = 0;
        aborted = 1'b0;
        rst_n = 1'b0;
        start_valid = 1'b0;
        k_dim = '0;
        m_dim = '0;
        n_dim = '0;
        fill_buffers();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("start_ready", C_WORD_W'(start_ready), C_WORD_W'(1'b1));
        check_value("c_wr_en", C_WORD_W'(c_wr_en), C_WORD_W'(1'b0));
        check_value("a_index", C_WORD_W'(a_index), C_WORD_W'(0));
        check_value("b_index", C_WORD_W'(b_index), C_WORD_W'(0));
        check_value("c_index", C_WORD_W'(c_index), C_WORD_W'(0));

        // smallest job then an exact multiple of the grid back to back
        run_job(1, 1, 1, 1'b0);
        if (!aborted) begin
            run_job(8, 8, 8, 1'b1);
        end
        for (int j = 0; j < 10 && !aborted; j++) begin
            k = int'($urandom % 20) + 1;
            m = int'($urandom % 13) + 1;
            n = int'($urandom % 13) + 1;
            hold = ($urandom % 2) == 1;
            gap = int'($urandom % 3);
            idle_cycles(gap);
            run_job(k, m, n, hold);
        end
        if (!aborted) begin
            idle_cycles(4);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
src/tpu_pkg.sv
src/tile_sequencer.sv
src/operand_skew.sv
src/mac_pe.sv
src/result_drain.sv
src/systolic_tpu.sv
tests/tb_systolic_tpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the systolic engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_systolic_tpu -f flist.f -o sim_tpu

status=0
./obj_dir/sim_tpu > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "testbench reported failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation did not complete"
    exit 1
fi
